// File: src/setup_consts.svh
// Width, cacheline and FIFO sizing constants for the kernel setup stage
`ifndef SETUP_CONSTS_SVH
`define SETUP_CONSTS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SETUP_ADDR_W 64
`define SETUP_DATA_W 64
`define SETUP_ID_W 8

// Bytes per cacheline
`define SETUP_LINE_BYTES 64

// ------------------------------
// FIFO sizing
// ------------------------------
`define SETUP_FIFO_DEPTH 4
// Cycles the FIFO stays busy after reset is released
`define SETUP_FIFO_RST_CYCLES 4

`endif

// File: src/setup_pkg.sv
// Descriptor, memory request/response, FIFO status, engine config and FSM state types
`default_nettype none

`include "setup_consts.svh"

package setup_pkg;

    // Kernel descriptor
    typedef struct packed {
        logic [`SETUP_ADDR_W-1:0] graph_csr_struct;
    } descriptor_payload_t;

    typedef struct packed {
        logic                valid;
        descriptor_payload_t payload;
    } descriptor_t;

    // ------------------------------
    // Memory side packets
    // ------------------------------
    typedef struct packed {
        logic [`SETUP_ADDR_W-1:0] address;
        logic [`SETUP_ID_W-1:0]   cacheline_id;
    } mem_req_payload_t;

    typedef struct packed {
        logic             valid;
        mem_req_payload_t payload;
    } mem_req_t;

    typedef struct packed {
        logic [`SETUP_ID_W-1:0]   cacheline_id;
        logic [`SETUP_DATA_W-1:0] data;
    } mem_resp_payload_t;

    typedef struct packed {
        logic              valid;
        mem_resp_payload_t payload;
    } mem_resp_t;

    // Status levels of one FIFO
    typedef struct packed {
        logic full;
        logic almost_full;
        logic empty;
        logic valid;
        logic rst_busy;
    } fifo_status_t;

    // ------------------------------
    // Read engine configuration
    // ------------------------------
    // One extra bit so a full id range can be counted
    typedef logic [`SETUP_ID_W:0] line_count_t;
    // Stride in cachelines
    typedef logic [15:0] stride_t;

    typedef struct packed {
        logic [`SETUP_ADDR_W-1:0] array_pointer;
        line_count_t              count;
        stride_t                  stride;
    } read_config_payload_t;

    typedef struct packed {
        logic                 valid;
        read_config_payload_t payload;
    } read_config_t;

    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_REQ_DONE
    } setup_state_t;

endpackage

`default_nettype wire

// File: src/setup_fifo.sv
// Synchronous FIFO with typed payload, first-word valid strobe, status flags and reset-busy window
`timescale 1ns/1ps
`default_nettype none

`include "setup_consts.svh"

module setup_fifo
    import setup_pkg::*;
#(
    parameter type T_PAYLOAD = mem_req_payload_t
) (
    input  wire logic     ap_clk,
    input  wire logic     setup_areset,
    input  wire T_PAYLOAD din,
    input  wire logic     wr_en,
    input  wire logic     rd_en,
    output T_PAYLOAD      dout,
    output fifo_status_t  status
);

    localparam int DEPTH  = `SETUP_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BUSY_W = $clog2(`SETUP_FIFO_RST_CYCLES + 1);

    T_PAYLOAD          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  occupancy;
    logic [BUSY_W-1:0] busy_cnt;
    logic              rst_busy;
    logic              out_valid;
    logic              full;
    logic              empty;
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (occupancy == CNT_W'(DEPTH));
    assign empty   = (occupancy == '0);
    // Both ports stay closed while the FIFO comes out of reset
    assign do_push = wr_en && !full && !rst_busy;
    assign do_pop  = rd_en && !empty && !rst_busy;

    // Almost full covers the last free slot and the full case
    assign status = '{full        : full,
                      almost_full : (occupancy >= CNT_W'(DEPTH - 1)),
                      empty       : empty,
                      valid       : out_valid,
                      rst_busy    : rst_busy};

    // ------------------------------
    // Pointers, count, busy window
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            out_valid <= 1'b0;
            busy_cnt  <= BUSY_W'(`SETUP_FIFO_RST_CYCLES);
            rst_busy  <= 1'b1;
        end else begin
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            rst_busy <= (busy_cnt > BUSY_W'(1));
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            out_valid <= do_pop;
        end
    end

    // Storage and read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
        if (do_pop) begin
            dout <= mem[rd_ptr];
        end
    end

    // Writer has to watch the full flag
    a_no_write_full: assert property (@(posedge ap_clk) disable iff (setup_areset)
        !(wr_en && full));

    // A popped word always comes from a written slot
    a_valid_word_known: assert property (@(posedge ap_clk) disable iff (setup_areset)
        out_valid |-> !$isunknown(dout));

endmodule

`default_nettype wire

// File: src/serial_read_engine.sv
// Serial read engine issuing one cacheline read request per cycle into the request FIFO
`timescale 1ns/1ps
`default_nettype none

`include "setup_consts.svh"

module serial_read_engine
    import setup_pkg::*;
(
    input  wire logic         ap_clk,
    input  wire logic         setup_areset,
    input  wire read_config_t read_config,
    input  wire logic         start,
    input  wire fifo_status_t fifo_status,
    output mem_req_t          req_out,
    output logic              ready,
    output logic              done,
    output logic              busy
);

    logic                     start_q;
    logic                     start_evt;
    line_count_t              index;
    line_count_t              count_q;
    logic [`SETUP_ADDR_W-1:0] next_addr;
    logic [`SETUP_ADDR_W-1:0] step_bytes;
    logic                     last_sent;
    logic                     issue;
    logic                     req_valid;
    mem_req_payload_t         req_payload;

    // A run begins on the rising edge of start
    assign start_evt = start && !start_q && read_config.valid;
    assign last_sent = (index == count_q);

    // Hold back while the FIFO has one slot or less to cover the write in flight
    assign issue = busy && !start_evt && !last_sent
                   && !fifo_status.almost_full && !fifo_status.rst_busy;

    assign req_out = '{valid: req_valid, payload: req_payload};

    // ------------------------------
    // Run control
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            start_q   <= 1'b0;
            ready     <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            req_valid <= 1'b0;
            index     <= '0;
        end else begin
            start_q   <= start;
            ready     <= start_evt;
            req_valid <= issue;
            if (start_evt) begin
                busy  <= 1'b1;
                done  <= 1'b0;
                index <= '0;
            end else if (busy) begin
                if (last_sent) begin
                    // done follows the last request by a cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (issue) begin
                    index <= index + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Address generation
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (start_evt) begin
            count_q    <= read_config.payload.count;
            next_addr  <= read_config.payload.array_pointer;
            step_bytes <= `SETUP_ADDR_W'(read_config.payload.stride)
                          * `SETUP_ADDR_W'(`SETUP_LINE_BYTES);
        end else if (issue) begin
            next_addr <= next_addr + step_bytes;
        end
    end

    // Request payload for the FIFO write port
    always_ff @(posedge ap_clk) begin
        if (issue) begin
            req_payload.address      <= next_addr;
            req_payload.cacheline_id <= index[`SETUP_ID_W-1:0];
        end
    end

    // The almost full margin keeps every write off a full FIFO
    a_no_req_into_full: assert property (@(posedge ap_clk) disable iff (setup_areset)
        req_out.valid |-> !fifo_status.full);

endmodule

`default_nettype wire

// File: src/kernel_setup.sv
// Kernel setup top level with input registers, setup FSM, read engine and request/response FIFOs
`timescale 1ns/1ps
`default_nettype none

`include "setup_consts.svh"

module kernel_setup
    import setup_pkg::*;
#(
    parameter int NUM_SETUP_CACHELINE = 2
) (
    input  wire logic        ap_clk,
    input  wire logic        setup_areset,
    input  wire descriptor_t descriptor,
    input  wire mem_resp_t   mem_resp,
    input  wire logic        req_pop,
    input  wire logic        resp_pop,
    output mem_req_t         mem_req,
    output mem_resp_t        resp_out,
    output fifo_status_t     req_fifo_status,
    output fifo_status_t     resp_fifo_status,
    output logic             fifo_setup_signal,
    output logic             setup_done
);

    // Local copies of the reset
    logic ctrl_areset;
    logic engine_areset;
    logic fifo_areset;

    // Registered inputs
    logic                desc_valid_q;
    descriptor_payload_t desc_payload_q;
    logic                resp_valid_q;
    mem_resp_payload_t   resp_payload_q;
    logic                req_pop_q;
    logic                resp_pop_q;

    // FSM and engine side
    setup_state_t             state;
    setup_state_t             next_state;
    logic [`SETUP_ADDR_W-1:0] graph_base;
    read_config_t             read_config;
    logic                     engine_start;
    logic                     engine_ready;
    logic                     engine_done;
    logic                     engine_busy;
    mem_req_t                 engine_req;
    logic                     setup_complete;

    // FIFO read side and output registers
    mem_req_payload_t  req_dout;
    mem_resp_payload_t resp_dout;
    logic              req_out_valid;
    mem_req_payload_t  req_out_payload;
    logic              resp_out_valid;
    mem_resp_payload_t resp_out_payload;

    // ------------------------------
    // Reset fan-out
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        ctrl_areset   <= setup_areset;
        engine_areset <= setup_areset;
        fifo_areset   <= setup_areset;
    end

    // ------------------------------
    // Input registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (ctrl_areset) begin
            desc_valid_q <= 1'b0;
            resp_valid_q <= 1'b0;
            req_pop_q    <= 1'b0;
            resp_pop_q   <= 1'b0;
        end else begin
            desc_valid_q <= descriptor.valid;
            resp_valid_q <= mem_resp.valid;
            req_pop_q    <= req_pop;
            resp_pop_q   <= resp_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_payload_q <= descriptor.payload;
        resp_payload_q <= mem_resp.payload;
    end

    // ------------------------------
    // Setup FSM
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (ctrl_areset) begin
            state <= SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    // Requests all issued and drained from the request FIFO
    assign setup_complete = engine_done && req_fifo_status.empty;

    always_comb begin
        next_state = state;
        case (state)
            SETUP_RESET: begin
                next_state = SETUP_IDLE;
            end
            SETUP_IDLE: begin
                if (desc_valid_q) begin
                    next_state = SETUP_REQ_START;
                end
            end
            SETUP_REQ_START: begin
                if (engine_ready || engine_done) begin
                    next_state = SETUP_REQ_BUSY;
                end
            end
            SETUP_REQ_BUSY: begin
                if (setup_complete) begin
                    next_state = SETUP_REQ_DONE;
                end
            end
            // Stays here until reset so later descriptors are ignored
            SETUP_REQ_DONE: begin
                next_state = SETUP_REQ_DONE;
            end
            default: begin
                next_state = SETUP_RESET;
            end
        endcase
    end

    // Base address of the setup region
    always_ff @(posedge ap_clk) begin
        if (state == SETUP_IDLE && desc_valid_q) begin
            graph_base <= desc_payload_q.graph_csr_struct;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ctrl_areset) begin
            setup_done        <= 1'b0;
            fifo_setup_signal <= 1'b1;
        end else begin
            setup_done        <= (state == SETUP_REQ_DONE);
            fifo_setup_signal <= engine_busy || req_fifo_status.rst_busy
                                 || resp_fifo_status.rst_busy;
        end
    end

    // ------------------------------
    // Read engine
    // ------------------------------
    assign engine_start = (state == SETUP_REQ_START);

    // Contiguous lines from the descriptor base
    assign read_config = '{valid   : engine_start,
                           payload : '{array_pointer : graph_base,
                                       count         : line_count_t'(NUM_SETUP_CACHELINE),
                                       stride        : stride_t'(1)}};

    serial_read_engine u_engine (
        .ap_clk       (ap_clk),
        .setup_areset (engine_areset),
        .read_config  (read_config),
        .start        (engine_start),
        .fifo_status  (req_fifo_status),
        .req_out      (engine_req),
        .ready        (engine_ready),
        .done         (engine_done),
        .busy         (engine_busy)
    );

    // ------------------------------
    // Request and response FIFOs
    // ------------------------------
    setup_fifo #(
        .T_PAYLOAD (mem_req_payload_t)
    ) u_req_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (fifo_areset),
        .din          (engine_req.payload),
        .wr_en        (engine_req.valid),
        .rd_en        (req_pop_q),
        .dout         (req_dout),
        .status       (req_fifo_status)
    );

    setup_fifo #(
        .T_PAYLOAD (mem_resp_payload_t)
    ) u_resp_fifo (
        .ap_clk       (ap_clk),
        .setup_areset (fifo_areset),
        .din          (resp_payload_q),
        .wr_en        (resp_valid_q),
        .rd_en        (resp_pop_q),
        .dout         (resp_dout),
        .status       (resp_fifo_status)
    );

    // Output registers capture the payload only with a valid word
    always_ff @(posedge ap_clk) begin
        if (ctrl_areset) begin
            req_out_valid  <= 1'b0;
            resp_out_valid <= 1'b0;
        end else begin
            req_out_valid  <= req_fifo_status.valid;
            resp_out_valid <= resp_fifo_status.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_fifo_status.valid) begin
            req_out_payload <= req_dout;
        end
        if (resp_fifo_status.valid) begin
            resp_out_payload <= resp_dout;
        end
    end

    assign mem_req  = '{valid: req_out_valid, payload: req_out_payload};
    assign resp_out = '{valid: resp_out_valid, payload: resp_out_payload};

endmodule

`default_nettype wire

// File: bench/kernel_setup_tb.sv
// Testbench for kernel_setup with memory responder, random pops, reference model and timeout
`timescale 1ns/1ps
`default_nettype none

`include "setup_consts.svh"

module kernel_setup_tb
    import setup_pkg::*;
;

    localparam int NUM_LINES = 7;
    // Two runs of well under 300 cycles each, a 60-cycle stall, a 100-cycle idle check
    localparam int CYCLE_LIMIT = 2000;
    localparam logic [63:0] BASE_A = 64'h0000_0040_0001_0000;
    localparam logic [63:0] BASE_B = 64'h0000_7f00_0a3c_1fc0;

    logic            ap_clk;
    logic            setup_areset;
    descriptor_t     descriptor;
    mem_resp_t       mem_resp;
    logic            req_pop;
    logic            resp_pop;
    mem_req_t        mem_req;
    mem_resp_t       resp_out;
    fifo_status_t    req_fifo_status;
    fifo_status_t    resp_fifo_status;
    logic            fifo_setup_signal;
    logic            setup_done;

    // Bench state
    logic             traffic_on;
    logic             mon_on;
    logic             req_pop_en;
    logic [31:0]      rng;
    logic [1:0]       recent_present;
    logic [63:0]      base_addr;
    mem_req_payload_t resp_todo[$];
    int               req_cnt;
    int               resp_cnt;
    int               cycle_cnt;
    logic             full_seen;
    logic             done_seen;

    kernel_setup #(
        .NUM_SETUP_CACHELINE (NUM_LINES)
    ) u_dut (
        .ap_clk            (ap_clk),
        .setup_areset      (setup_areset),
        .descriptor        (descriptor),
        .mem_resp          (mem_resp),
        .req_pop           (req_pop),
        .resp_pop          (resp_pop),
        .mem_req           (mem_req),
        .resp_out          (resp_out),
        .req_fifo_status   (req_fifo_status),
        .resp_fifo_status  (resp_fifo_status),
        .fifo_setup_signal (fifo_setup_signal),
        .setup_done        (setup_done)
    );

    always #2 ap_clk = ~ap_clk;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [63:0] expected_addr(input logic [63:0] base, input int i);
        return base + 64'(i) * 64'(`SETUP_LINE_BYTES);
    endfunction

    function automatic logic [63:0] expected_data(input logic [63:0] addr);
        return addr ^ 64'hc3a5_5a3c_0ff0_9669;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            report_failure("value mismatch");
        end
    endtask

    // Random pops and memory responder
    always @(posedge ap_clk) begin : drive_traffic
        mem_req_payload_t popped;
        mem_resp_t        resp_word;
        logic             present;
        rng       = xorshift32(rng);
        present   = 1'b0;
        resp_word = '0;
        // Two quiet cycles before each response keep the response FIFO off full
        if (traffic_on && resp_todo.size() > 0 && rng[3:2] != 2'b00
            && recent_present == 2'b00 && !resp_fifo_status.almost_full) begin
            popped                         = resp_todo.pop_front();
            resp_word.valid                = 1'b1;
            resp_word.payload.cacheline_id = popped.cacheline_id;
            resp_word.payload.data         = expected_data(popped.address);
            present                        = 1'b1;
        end
        recent_present = {recent_present[0], present};
        mem_resp <= resp_word;
        req_pop  <= traffic_on && req_pop_en && rng[0];
        resp_pop <= traffic_on && rng[1];
    end

    // ------------------------------
    // Output comparison
    // ------------------------------
    always @(negedge ap_clk) begin
        if (mon_on) begin
            if (req_fifo_status.full) begin
                full_seen = 1'b1;
            end
            check_value("resp_fifo_status.full", 64'(resp_fifo_status.full), 64'd0);
            if (done_seen && !setup_done) begin
                report_failure("setup_done fell again before reset");
            end
            if (setup_done && req_cnt != NUM_LINES) begin
                report_failure("setup_done rose before all requests left on mem_req");
            end
            done_seen = done_seen || setup_done;
            if (mem_req.valid) begin
                if (req_cnt >= NUM_LINES) begin
                    report_failure("request seen after all setup cachelines were issued");
                end
                check_value("mem_req.address", mem_req.payload.address,
                            expected_addr(base_addr, req_cnt));
                check_value("mem_req.cacheline_id", 64'(mem_req.payload.cacheline_id),
                            64'(req_cnt));
                resp_todo.push_back(mem_req.payload);
                req_cnt++;
            end
            if (resp_out.valid) begin
                check_value("resp_out.cacheline_id", 64'(resp_out.payload.cacheline_id),
                            64'(resp_cnt));
                check_value("resp_out.data", resp_out.payload.data,
                            expected_data(expected_addr(base_addr, resp_cnt)));
                resp_cnt++;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure("timeout, the tests did not finish within the cycle limit");
        end
    end

    task automatic apply_reset();
        @(posedge ap_clk);
        traffic_on   <= 1'b0;
        mon_on       <= 1'b0;
        req_pop_en   <= 1'b0;
        setup_areset <= 1'b1;
        descriptor   <= '0;
        repeat (3) @(posedge ap_clk);
        resp_todo.delete();
        req_cnt        = 0;
        resp_cnt       = 0;
        full_seen      = 1'b0;
        done_seen      = 1'b0;
        recent_present = 2'b00;
        setup_areset <= 1'b0;
    endtask

    task automatic check_after_reset();
        int wait_cycles;
        @(posedge ap_clk);
        check_value("fifo_setup_signal", 64'(fifo_setup_signal), 64'd1);
        check_value("setup_done", 64'(setup_done), 64'd0);
        check_value("mem_req.valid", 64'(mem_req.valid), 64'd0);
        check_value("resp_out.valid", 64'(resp_out.valid), 64'd0);
        wait_cycles = 0;
        while (fifo_setup_signal !== 1'b0) begin
            if (wait_cycles >= `SETUP_FIFO_RST_CYCLES + 4) begin
                report_failure("fifo_setup_signal did not fall after reset");
            end
            @(posedge ap_clk);
            wait_cycles++;
        end
        // Nothing should move while idle
        repeat (10) begin
            @(posedge ap_clk);
            check_value("fifo_setup_signal", 64'(fifo_setup_signal), 64'd0);
            check_value("mem_req.valid", 64'(mem_req.valid), 64'd0);
        end
    endtask

    task automatic send_descriptor(input logic [63:0] base);
        descriptor_t desc;
        desc.valid                    = 1'b1;
        desc.payload.graph_csr_struct = base;
        descriptor <= desc;
        @(posedge ap_clk);
        desc.valid = 1'b0;
        descriptor <= desc;
    endtask

    task automatic run_setup(input logic [63:0] base, input logic hold_pops);
        @(posedge ap_clk);
        base_addr = base;
        mon_on     <= 1'b1;
        traffic_on <= 1'b1;
        req_pop_en <= !hold_pops;
        send_descriptor(base);
        if (hold_pops) begin
            repeat (59) @(posedge ap_clk);
            if (!full_seen) begin
                report_failure("request FIFO never reported full while pops were withheld");
            end
            check_value("setup_done", 64'(setup_done), 64'd0);
            check_value("requests while withheld", 64'(req_cnt), 64'd0);
            req_pop_en <= 1'b1;
        end
        while (req_cnt < NUM_LINES) @(posedge ap_clk);
        while (setup_done !== 1'b1) @(posedge ap_clk);
        while (resp_cnt < NUM_LINES) @(posedge ap_clk);
        // Both FIFOs drained once every response has left
        check_value("req_fifo_status.empty", 64'(req_fifo_status.empty), 64'd1);
        check_value("resp_fifo_status.empty", 64'(resp_fifo_status.empty), 64'd1);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        ap_clk         = 1'b0;
        setup_areset   = 1'b1;
        descriptor     = '0;
        mem_resp       = '0;
        req_pop        = 1'b0;
        resp_pop       = 1'b0;
        traffic_on     = 1'b0;
        mon_on         = 1'b0;
        req_pop_en     = 1'b0;
        rng            = 32'hd9c5fc21;
        recent_present = 2'b00;
        base_addr      = '0;
        req_cnt        = 0;
        resp_cnt       = 0;
        cycle_cnt      = 0;
        full_seen      = 1'b0;
        done_seen      = 1'b0;

        apply_reset();
        check_after_reset();
        run_setup(BASE_A, 1'b0);

        // A new descriptor must not start anything in the done state
        send_descriptor(BASE_A + 64'h1000);
        repeat (100) @(posedge ap_clk);
        check_value("setup_done", 64'(setup_done), 64'd1);

        apply_reset();
        check_after_reset();
        run_setup(BASE_B, 1'b1);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: kernel_setup.f
+incdir+src
src/setup_pkg.sv
src/setup_fifo.sv
src/serial_read_engine.sv
src/kernel_setup.sv
bench/kernel_setup_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the kernel setup testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f kernel_setup.f \
    --top-module kernel_setup_tb \
    -o kernel_setup_sim

# The simulator exits non-zero on $fatal, so the output decides the result
sim_out=$(./obj_dir/kernel_setup_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "Everything OK"; then
    exit 0
else
    exit 1
fi
